// ==== all.f ====
verilog/bus_pkg.sv
verilog/clint_timer.sv
verilog/lsu_read_router.sv
verilog/bus_arbiter.sv
verilog/soc_bus_top.sv
testbench/tb_soc_bus.sv

// ==== Makefile ====
TOP := tb_soc_bus

run:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module soc_bus_top -f all.f

clean:
	rm -rf obj_dir

.PHONY: run lint clean

// ==== testbench/tb_soc_bus.sv ====
module tb_soc_bus;

  import bus_pkg::*;

  localparam int n_fetch    = 80;
  localparam int n_lsu      = 120;
  localparam int max_cycles = 40 * (n_fetch + n_lsu);

  logic        clock, reset;
  logic [31:0] araddr_0, rdata_0, araddr_1, rdata_1, awaddr_1, wdata_1;
  logic        arvalid_0, arready_0, rvalid_0, rlast_0, rready_0;
  logic        arvalid_1, arready_1, rvalid_1, rready_1, awvalid_1, awready_1;
  logic        wvalid_1, wready_1, bvalid_1, bready_1;
  logic [2:0]  arsize_1, awsize_1, io_master_awsize, io_master_arsize;
  logic [1:0]  rresp_0, rresp_1, bresp_1, io_master_bresp, io_master_rresp;
  logic [1:0]  io_master_awburst, io_master_arburst;
  logic [3:0]  wstrb_1, io_master_wstrb, io_master_awid, io_master_bid;
  logic [3:0]  io_master_arid, io_master_rid;
  logic [7:0]  io_master_awlen, io_master_arlen;
  logic [31:0] io_master_awaddr, io_master_wdata, io_master_araddr, io_master_rdata;
  logic        io_master_awready, io_master_awvalid, io_master_wready, io_master_wvalid;
  logic        io_master_wlast, io_master_bready, io_master_bvalid, io_master_arready;
  logic        io_master_arvalid, io_master_rready, io_master_rvalid, io_master_rlast;

  logic [31:0] mem [logic [31:0]];      // what the external slave holds
  logic [31:0] ref_mem [logic [31:0]];  // reference copy
  mtime_t      model_time;              // mirrors mtime
  logic [31:0] rng_f, rng_l, rng_s;
  logic        fetch_busy, lsu_rd_busy, lsu_wr_busy;

  logic [31:0] rd_addr, aw_addr, w_data;
  logic [8:0]  rd_left;
  logic [3:0]  w_strb;
  logic        rd_busy, aw_got, w_got, b_pend;

  soc_bus_top u_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic logic [31:0] slave_word(input logic [31:0] a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic fetch_burst(input logic [31:0] addr);
    int beats;
    beats = 0;
    fetch_busy = 1'b1;
    araddr_0  <= addr;
    arvalid_0 <= 1'b1;
    @(posedge clock);
    while (!arready_0) @(posedge clock);
    arvalid_0 <= 1'b0;
    while (beats < 2) begin
      rng_f = xorshift(rng_f);
      rready_0 <= rng_f[0] | rng_f[1];
      @(posedge clock);
      if (rvalid_0 && rready_0) begin
        check("rdata_0", model_word(addr + 32'(4 * beats)), rdata_0);
        check("rlast_0", 32'(beats == 1), 32'(rlast_0));
        check("rresp_0", 32'(resp_okay), 32'(rresp_0));
        beats++;
      end
    end
    rready_0 <= 1'b0;
    fetch_busy = 1'b0;
  endtask

  task automatic lsu_read(input logic [31:0] addr);
    logic [31:0] t_start;
    t_start = model_time.half.lo;
    lsu_rd_busy = 1'b1;
    araddr_1  <= addr;
    arsize_1  <= 3'b010;
    arvalid_1 <= 1'b1;
    @(posedge clock);
    while (!arready_1) @(posedge clock);
    arvalid_1 <= 1'b0;
    do begin
      rng_l = xorshift(rng_l);
      rready_1 <= rng_l[0] | rng_l[1];
      @(posedge clock);
    end while (!(rvalid_1 && rready_1));
    check("rresp_1", 32'(resp_okay), 32'(rresp_1));
    if (addr == mtime_hi_addr) begin
      check("rdata_1 mtime hi", model_time.half.hi, rdata_1);
    end else if (addr == mtime_lo_addr) begin
      // any count seen while the read was in flight
      if (rdata_1 < t_start) begin
        check("rdata_1 mtime lo", t_start, rdata_1);
      end
      if (rdata_1 > model_time.half.lo) begin
        check("rdata_1 mtime lo", model_time.half.lo, rdata_1);
      end
    end else begin
      check("rdata_1", model_word(addr), rdata_1);
    end
    rready_1 <= 1'b0;
    lsu_rd_busy = 1'b0;
  endtask

  task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    lsu_wr_busy = 1'b1;
    {awaddr_1, awsize_1, awvalid_1} <= {addr, 3'b010, 1'b1};
    {wdata_1, wstrb_1, wvalid_1} <= {data, strb, 1'b1};
    while (!(aw_done && w_done)) begin
      @(posedge clock);
      if (awvalid_1 && awready_1) begin
        aw_done = 1'b1;
        awvalid_1 <= 1'b0;
      end
      if (wvalid_1 && wready_1) begin
        w_done = 1'b1;
        wvalid_1 <= 1'b0;
      end
    end
    do begin
      rng_l = xorshift(rng_l);
      bready_1 <= rng_l[0] | rng_l[1];
      @(posedge clock);
    end while (!(bvalid_1 && bready_1));
    check("bresp_1", 32'(resp_okay), 32'(bresp_1));
    ref_mem[addr] = merge_bytes(model_word(addr), data, strb);
    bready_1 <= 1'b0;
    lsu_wr_busy = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    if (reset) model_time.count <= '0;
    else model_time.count <= model_time.count + 64'd1;
    if (!reset && model_time.count >= 64'(max_cycles)) begin
      $display("ERRORS FOUND");
      $fatal(1, "timeout: bus traffic did not finish within %0d cycles", max_cycles);
    end
  end

  // a response nobody is waiting for
  always @(negedge clock) begin
    if (!reset) begin
      if (!fetch_busy) check("rvalid_0", 32'd0, 32'(rvalid_0));
      if (!lsu_rd_busy) check("rvalid_1", 32'd0, 32'(rvalid_1));
      if (!lsu_wr_busy) check("bvalid_1", 32'd0, 32'(bvalid_1));
    end
  end

  // external AXI4 slave serving one read burst at a time
  initial begin
    rng_s = 32'hd117;
    {rd_addr, rd_left, rd_busy, aw_got, w_got, b_pend} = '0;
    {io_master_awready, io_master_wready, io_master_bvalid, io_master_bid} <= '0;
    {io_master_bresp, io_master_arready, io_master_rvalid, io_master_rid} <= '0;
    {io_master_rdata, io_master_rresp, io_master_rlast} <= '0;
    forever begin
      @(posedge clock);
      rng_s = xorshift(rng_s);
      if (io_master_rvalid && io_master_rready) begin
        rd_addr = rd_addr + 32'd4;
        rd_left = rd_left - 9'd1;
        rd_busy = (rd_left != 9'd0);
      end
      if (io_master_arvalid && io_master_arready) begin
        check("io_master_arid", 32'd0, 32'(io_master_arid));
        check("io_master_arsize", 32'd2, 32'(io_master_arsize));  // 4-byte beats
        check("io_master_arburst", 32'd1, 32'(io_master_arburst));  // INCR
        // load/store words sit at 0x8001_xxxx and take one beat
        check("io_master_arlen", io_master_araddr[16] ? 32'd0 : 32'd1,
              32'(io_master_arlen));
        rd_addr = {io_master_araddr[31:2], 2'b00};
        rd_left = 9'(io_master_arlen) + 9'd1;
        rd_busy = 1'b1;
      end
      if (!(io_master_rvalid && !io_master_rready)) begin  // else hold the beat
        io_master_rvalid <= rd_busy & rng_s[2];
        io_master_rdata  <= slave_word(rd_addr);
        io_master_rlast  <= (rd_left == 9'd1);
      end
      io_master_arready <= rng_s[0] | rng_s[1];
      if (io_master_awvalid && io_master_awready) begin
        check("io_master_awid", 32'd0, 32'(io_master_awid));
        check("io_master_awlen", 32'd0, 32'(io_master_awlen));
        check("io_master_awsize", 32'd2, 32'(io_master_awsize));
        check("io_master_awburst", 32'd1, 32'(io_master_awburst));
        aw_got  = 1'b1;
        aw_addr = {io_master_awaddr[31:2], 2'b00};
      end
      if (io_master_wvalid && io_master_wready) begin
        check("io_master_wlast", 32'd1, 32'(io_master_wlast));
        w_got  = 1'b1;
        w_data = io_master_wdata;
        w_strb = io_master_wstrb;
      end
      if (io_master_bvalid && io_master_bready) b_pend = 1'b0;
      if (aw_got && w_got && !b_pend) begin
        mem[aw_addr] = merge_bytes(slave_word(aw_addr), w_data, w_strb);
        {aw_got, w_got, b_pend} = 3'b001;
      end
      io_master_bvalid  <= b_pend;
      io_master_awready <= !aw_got && rng_s[3];
      io_master_wready  <= !w_got && rng_s[4];
    end
  end

  initial begin
    reset <= 1'b1;
    {araddr_0, arvalid_0, rready_0, araddr_1, arsize_1, arvalid_1, rready_1} <= '0;
    {awaddr_1, awsize_1, awvalid_1, wdata_1, wstrb_1, wvalid_1, bready_1} <= '0;
    rng_f = xorshift(32'hd117);
    rng_l = xorshift(rng_f);
    {fetch_busy, lsu_rd_busy, lsu_wr_busy} = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    check("arready_1", 32'd0, 32'(arready_1));
    check("io_master_arvalid", 32'd0, 32'(io_master_arvalid));
    fork
      begin
        for (int i = 0; i < n_fetch; i++) begin
          rng_f = xorshift(rng_f);
          repeat (rng_f[5:4]) @(posedge clock);
          fetch_burst(32'h8000_0000 | (rng_f & 32'h0000_0ff8));
        end
      end
      begin
        for (int i = 0; i < n_lsu; i++) begin
          rng_l = xorshift(rng_l);
          repeat (rng_l[5:4]) @(posedge clock);
          if (rng_l[6]) lsu_write(32'h8001_0000 | (rng_l & 32'h3c),
                                  {rng_l[15:0], rng_l[31:16]}, rng_l[12:9]);
          else if (rng_l[8:7] == 2'd0) lsu_read(rng_l[9] ? mtime_hi_addr : mtime_lo_addr);
          else lsu_read(32'h8001_0000 | (rng_l & 32'h3c));
        end
      end
    join
    repeat (2) @(posedge clock);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== verilog/soc_bus_top.sv ====
module soc_bus_top (
  input  logic        clock,
  input  logic        reset,

  input  logic [31:0] araddr_0,
  input  logic        arvalid_0,
  output logic        arready_0,
  output logic [31:0] rdata_0,
  output logic [1:0]  rresp_0,
  output logic        rvalid_0,
  output logic        rlast_0,
  input  logic        rready_0,

  input  logic [31:0] araddr_1,
  input  logic [2:0]  arsize_1,
  input  logic        arvalid_1,
  output logic        arready_1,
  output logic [31:0] rdata_1,
  output logic [1:0]  rresp_1,
  output logic        rvalid_1,
  input  logic        rready_1,
  input  logic [31:0] awaddr_1,
  input  logic [2:0]  awsize_1,
  input  logic        awvalid_1,
  output logic        awready_1,
  input  logic [31:0] wdata_1,
  input  logic [3:0]  wstrb_1,
  input  logic        wvalid_1,
  output logic        wready_1,
  output logic [1:0]  bresp_1,
  output logic        bvalid_1,
  input  logic        bready_1,

  input  logic        io_master_awready,
  output logic        io_master_awvalid,
  output logic [3:0]  io_master_awid,
  output logic [31:0] io_master_awaddr,
  output logic [7:0]  io_master_awlen,
  output logic [2:0]  io_master_awsize,
  output logic [1:0]  io_master_awburst,
  input  logic        io_master_wready,
  output logic        io_master_wvalid,
  output logic [31:0] io_master_wdata,
  output logic [3:0]  io_master_wstrb,
  output logic        io_master_wlast,
  output logic        io_master_bready,
  input  logic        io_master_bvalid,
  input  logic [3:0]  io_master_bid,
  input  logic [1:0]  io_master_bresp,
  input  logic        io_master_arready,
  output logic        io_master_arvalid,
  output logic [3:0]  io_master_arid,
  output logic [31:0] io_master_araddr,
  output logic [7:0]  io_master_arlen,
  output logic [2:0]  io_master_arsize,
  output logic [1:0]  io_master_arburst,
  output logic        io_master_rready,
  input  logic        io_master_rvalid,
  input  logic [3:0]  io_master_rid,
  input  logic [31:0] io_master_rdata,
  input  logic [1:0]  io_master_rresp,
  input  logic        io_master_rlast
);

  // router to arbiter
  logic [31:0] mem_araddr;
  logic [2:0]  mem_arsize;
  logic        mem_arvalid;
  logic        mem_arready;
  logic [31:0] mem_rdata;
  logic [1:0]  mem_rresp;
  logic        mem_rvalid;
  logic        mem_rready;

  // router to timer
  logic        tmr_araddr_sel;
  logic        tmr_arvalid;
  logic        tmr_arready;
  logic [31:0] tmr_rdata;
  logic [1:0]  tmr_rresp;
  logic        tmr_rvalid;
  logic        tmr_rready;

  lsu_read_router u_router (.*);

  clint_timer u_timer (.*);

  bus_arbiter u_arbiter (.*);

endmodule

// ==== verilog/bus_arbiter.sv ====
module bus_arbiter (
  input  logic        clock,
  input  logic        reset,

  input  logic [31:0] araddr_0,
  input  logic        arvalid_0,
  output logic        arready_0,
  output logic [31:0] rdata_0,
  output logic [1:0]  rresp_0,
  output logic        rvalid_0,
  output logic        rlast_0,
  input  logic        rready_0,

  input  logic [31:0] mem_araddr,
  input  logic [2:0]  mem_arsize,
  input  logic        mem_arvalid,
  output logic        mem_arready,
  output logic [31:0] mem_rdata,
  output logic [1:0]  mem_rresp,
  output logic        mem_rvalid,
  input  logic        mem_rready,

  input  logic [31:0] awaddr_1,
  input  logic [2:0]  awsize_1,
  input  logic        awvalid_1,
  output logic        awready_1,
  input  logic [31:0] wdata_1,
  input  logic [3:0]  wstrb_1,
  input  logic        wvalid_1,
  output logic        wready_1,
  output logic [1:0]  bresp_1,
  output logic        bvalid_1,
  input  logic        bready_1,

  input  logic        io_master_awready,
  output logic        io_master_awvalid,
  output logic [3:0]  io_master_awid,
  output logic [31:0] io_master_awaddr,
  output logic [7:0]  io_master_awlen,
  output logic [2:0]  io_master_awsize,
  output logic [1:0]  io_master_awburst,
  input  logic        io_master_wready,
  output logic        io_master_wvalid,
  output logic [31:0] io_master_wdata,
  output logic [3:0]  io_master_wstrb,
  output logic        io_master_wlast,
  output logic        io_master_bready,
  input  logic        io_master_bvalid,
  input  logic [3:0]  io_master_bid,
  input  logic [1:0]  io_master_bresp,
  input  logic        io_master_arready,
  output logic        io_master_arvalid,
  output logic [3:0]  io_master_arid,
  output logic [31:0] io_master_araddr,
  output logic [7:0]  io_master_arlen,
  output logic [2:0]  io_master_arsize,
  output logic [1:0]  io_master_arburst,
  output logic        io_master_rready,
  input  logic        io_master_rvalid,
  input  logic [3:0]  io_master_rid,
  input  logic [31:0] io_master_rdata,
  input  logic [1:0]  io_master_rresp,
  input  logic        io_master_rlast
);

  import bus_pkg::*;

  logic outstanding;
  logic owner;     // 1 = load/store
  logic ar_hold;   // arvalid waiting on arready
  logic hold_lsu;
  logic sel_lsu;
  logic ar_fire;
  logic r_beat;
  logic r_fire;

  // keep the choice fixed while the slave stalls the address
  assign sel_lsu = ar_hold ? hold_lsu : ~arvalid_0;
  assign ar_fire = io_master_arvalid & io_master_arready;

  always_ff @(posedge clock) begin
    if (reset) begin
      outstanding <= 1'b0;
      owner       <= 1'b0;
      ar_hold     <= 1'b0;
      hold_lsu    <= 1'b0;
    end else begin
      ar_hold  <= io_master_arvalid & ~io_master_arready;
      hold_lsu <= sel_lsu;
      if (ar_fire) begin
        outstanding <= 1'b1;
        owner       <= sel_lsu;
      end else if (r_fire && io_master_rlast) begin
        outstanding <= 1'b0;
      end
    end
  end

  assign io_master_arvalid = ~outstanding & (sel_lsu ? mem_arvalid : arvalid_0);
  assign io_master_arid    = 4'd0;
  assign io_master_araddr  = sel_lsu ? mem_araddr : araddr_0;
  assign io_master_arlen   = sel_lsu ? 8'd0 : fetch_len;
  assign io_master_arsize  = sel_lsu ? mem_arsize : fetch_size;
  assign io_master_arburst = burst_incr;
  assign arready_0   = ~outstanding & ~sel_lsu & io_master_arready;
  assign mem_arready = ~outstanding & sel_lsu & io_master_arready;

  // only ID 0 belongs to us
  assign r_beat = outstanding & io_master_rvalid & (io_master_rid == 4'd0);
  assign io_master_rready = outstanding & (owner ? mem_rready : rready_0);
  assign r_fire = r_beat & io_master_rready;

  assign rvalid_0   = r_beat & ~owner;
  assign rdata_0    = io_master_rdata;
  assign rresp_0    = io_master_rresp;
  assign rlast_0    = io_master_rlast;
  assign mem_rvalid = r_beat & owner;
  assign mem_rdata  = io_master_rdata;
  assign mem_rresp  = io_master_rresp;

  // load/store writes pass straight through
  assign io_master_awvalid = awvalid_1;
  assign io_master_awid    = 4'd0;
  assign io_master_awaddr  = awaddr_1;
  assign io_master_awlen   = 8'd0;
  assign io_master_awsize  = awsize_1;
  assign io_master_awburst = burst_incr;
  assign awready_1         = io_master_awready;
  assign io_master_wvalid  = wvalid_1;
  assign io_master_wdata   = wdata_1;
  assign io_master_wstrb   = wstrb_1;
  assign io_master_wlast   = wvalid_1;  // single beat
  assign wready_1          = io_master_wready;
  assign io_master_bready  = bready_1;
  assign bvalid_1          = io_master_bvalid & (io_master_bid == 4'd0);
  assign bresp_1           = io_master_bresp;

endmodule

// ==== verilog/lsu_read_router.sv ====
module lsu_read_router (
  input  logic        clock,
  input  logic        reset,

  input  logic [31:0] araddr_1,
  input  logic [2:0]  arsize_1,
  input  logic        arvalid_1,
  output logic        arready_1,
  output logic [31:0] rdata_1,
  output logic [1:0]  rresp_1,
  output logic        rvalid_1,
  input  logic        rready_1,

  output logic [31:0] mem_araddr,
  output logic [2:0]  mem_arsize,
  output logic        mem_arvalid,
  input  logic        mem_arready,
  input  logic [31:0] mem_rdata,
  input  logic [1:0]  mem_rresp,
  input  logic        mem_rvalid,
  output logic        mem_rready,

  output logic        tmr_araddr_sel,
  output logic        tmr_arvalid,
  input  logic        tmr_arready,
  input  logic [31:0] tmr_rdata,
  input  logic [1:0]  tmr_rresp,
  input  logic        tmr_rvalid,
  output logic        tmr_rready
);

  import bus_pkg::*;

  logic dec_valid;  // decode registered, address not yet taken
  logic busy;       // response pending
  logic tmr_hit;
  logic addr_is_tmr;

  assign addr_is_tmr = (araddr_1 == mtime_lo_addr) || (araddr_1 == mtime_hi_addr);

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
      busy      <= 1'b0;
      tmr_hit   <= 1'b0;
    end else begin
      if (!dec_valid && !busy && arvalid_1) begin
        dec_valid <= 1'b1;
        tmr_hit   <= addr_is_tmr;
      end
      if (dec_valid && arvalid_1 && arready_1) begin
        dec_valid <= 1'b0;
        busy      <= 1'b1;
      end
      // target flag stays put until here
      if (busy && rvalid_1 && rready_1) begin
        busy <= 1'b0;
      end
    end
  end

  // only one target sees arvalid
  assign mem_araddr     = araddr_1;
  assign mem_arsize     = arsize_1;
  assign mem_arvalid    = dec_valid & ~tmr_hit & arvalid_1;
  assign tmr_arvalid    = dec_valid & tmr_hit & arvalid_1;
  assign tmr_araddr_sel = (araddr_1 == mtime_hi_addr);
  assign arready_1      = dec_valid & (tmr_hit ? tmr_arready : mem_arready);

  // response side
  assign rdata_1    = tmr_hit ? tmr_rdata : mem_rdata;
  assign rresp_1    = tmr_hit ? tmr_rresp : mem_rresp;
  assign rvalid_1   = busy & (tmr_hit ? tmr_rvalid : mem_rvalid);
  assign mem_rready = busy & ~tmr_hit & rready_1;
  assign tmr_rready = busy & tmr_hit & rready_1;

endmodule

// ==== verilog/clint_timer.sv ====
module clint_timer (
  input  logic        clock,
  input  logic        reset,

  input  logic        tmr_araddr_sel,
  input  logic        tmr_arvalid,
  output logic        tmr_arready,

  output logic [31:0] tmr_rdata,
  output logic [1:0]  tmr_rresp,
  output logic        tmr_rvalid,
  input  logic        tmr_rready
);

  import bus_pkg::*;

  mtime_t mtime;
  logic   ar_fire;

  // single response slot
  assign tmr_arready = ~tmr_rvalid;
  assign ar_fire     = tmr_arvalid & tmr_arready;
  assign tmr_rresp   = resp_okay;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime.count <= '0;
    end else begin
      mtime.count <= mtime.count + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tmr_rvalid <= 1'b0;
    end else if (ar_fire) begin
      tmr_rvalid <= 1'b1;
    end else if (tmr_rready) begin
      tmr_rvalid <= 1'b0;  // handshake done
    end
  end

  // sample the counter in the accept cycle
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      tmr_rdata <= tmr_araddr_sel ? mtime.half.hi : mtime.half.lo;
    end
  end

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

  // core-local timer words
  localparam logic [31:0] mtime_lo_addr = 32'h0200_0048;
  localparam logic [31:0] mtime_hi_addr = 32'h0200_004c;

  // instruction fetch burst shape
  localparam logic [7:0] fetch_len  = 8'd1;    // two beats
  localparam logic [2:0] fetch_size = 3'b010;  // 4 bytes per beat

  localparam logic [1:0] burst_incr = 2'b01;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } mtime_half_t;

  // one 64-bit count, or two 32-bit words for the bus
  typedef union packed {
    logic [63:0] count;
    mtime_half_t half;
  } mtime_t;

endpackage
